// File: bus_pkg.sv
`default_nettype none

package bus_pkg;

    localparam int addr_width = 32;
    localparam int word_width = 32;

    // backing memory depth in words
    localparam int mem_words = 16384;

    typedef logic [addr_width-1:0] addr_t;
    typedef logic [word_width-1:0] word_t;

    typedef logic [7:0] burst_len_t;   // beats minus one

    typedef logic [$clog2(mem_words)-1:0] mem_index_t;

endpackage

`default_nettype wire

// File: cache_pkg.sv
`default_nettype none

package cache_pkg;

    // pc split: tag | index | word offset | byte
    localparam int tag_width    = 19;
    localparam int index_width  = 8;
    localparam int offset_width = 5;

    localparam int words_per_line = 1 << (offset_width - 2);
    localparam int sets           = 1 << index_width;

    typedef logic [tag_width-1:0]    tag_t;
    typedef logic [index_width-1:0]  index_t;
    typedef logic [offset_width-3:0] word_sel_t;   // word within a line

    // tag with its valid bit in the lsb
    typedef logic [tag_width:0] tag_entry_t;

    typedef enum logic [1:0] {
        idle,
        lookup,
        refill,
        uncached
    } icache_state_t;

endpackage

`default_nettype wire

// File: rd_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface rd_bus_if;
    import bus_pkg::*;

    // address channel
    addr_t      araddr;
    burst_len_t arlen;
    logic       arvalid;
    logic       arready;

    // read data channel
    word_t      rdata;
    logic       rvalid;
    logic       rlast;
    logic       rready;

    modport requester (
        output araddr, arlen, arvalid, rready,
        input  arready, rdata, rvalid, rlast
    );

    modport responder (
        input  araddr, arlen, arvalid, rready,
        output arready, rdata, rvalid, rlast
    );

endinterface

`default_nettype wire

// File: icache_ram.sv
`timescale 1ns/1ps
`default_nettype none

module icache_ram #(
    parameter int data_width = 32
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  we,
    input  cache_pkg::index_t     waddr,
    input  cache_pkg::index_t     raddr,
    input  logic [data_width-1:0] wdata,
    output logic [data_width-1:0] rdata
);
    import cache_pkg::*;

    logic [data_width-1:0] mem [sets];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, same-address write gives old data
    always_ff @(posedge clk) begin
        if (rst) begin
            rdata <= '0;
        end else begin
            rdata <= mem[raddr];
        end
    end

endmodule

`default_nettype wire

// File: icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache (
    input  logic             clk,
    input  logic             rst,
    input  logic             fetch_req,
    input  logic             fetch_no_cache,
    input  bus_pkg::addr_t   fetch_pc,
    output logic             fetch_valid,
    output logic             fetch_word1_valid,
    output bus_pkg::word_t   fetch_word0,
    output bus_pkg::word_t   fetch_word1,
    rd_bus_if.requester      bus
);
    import cache_pkg::*;
    import bus_pkg::*;

    icache_state_t state;

    addr_t      pc_q;
    logic       no_cache_q;
    tag_t       pc_tag;
    index_t     pc_idx;
    index_t     req_idx;
    word_sel_t  off0;
    word_sel_t  off1;
    word_sel_t  cnt;            // refill beat counter
    logic       last_word;

    // two ways
    tag_entry_t tag_rd [2];
    word_t      lane_rd [2][words_per_line];
    logic [sets-1:0] valid_q [2];
    logic [sets-1:0] lru_q;     // way to evict next

    logic [1:0] way_hit;
    logic       hit;
    logic       hit_way;
    logic       victim;
    logic       ar_pend;
    logic       beat;
    logic       beat_last;

    assign pc_tag    = pc_q[offset_width+index_width +: tag_width];
    assign pc_idx    = pc_q[offset_width +: index_width];
    assign off0      = pc_q[2 +: offset_width-2];
    assign off1      = off0 + 1'b1;
    assign last_word = &off0;    // no second word in this line
    assign req_idx   = fetch_pc[offset_width +: index_width];

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];
    assign victim  = lru_q[pc_idx];

    assign beat      = bus.rvalid && bus.rready;
    assign beat_last = beat && bus.rlast;

    for (genvar w = 0; w < 2; w++) begin : g_way
        icache_ram #(
            .data_width($bits(tag_entry_t))
        ) tag_ram (
            .clk   (clk),
            .rst   (rst),
            .we    ((state == refill) && beat_last && (victim == 1'(w))),
            .waddr (pc_idx),
            .raddr (req_idx),
            .wdata ({pc_tag, 1'b1}),
            .rdata (tag_rd[w])
        );

        assign way_hit[w] = valid_q[w][pc_idx] && (tag_rd[w] == {pc_tag, 1'b1});

        for (genvar l = 0; l < words_per_line; l++) begin : g_lane
            icache_ram #(
                .data_width($bits(word_t))
            ) data_ram (
                .clk   (clk),
                .rst   (rst),
                .we    ((state == refill) && beat && (victim == 1'(w))
                        && (cnt == word_sel_t'(l))),
                .waddr (pc_idx),
                .raddr (req_idx),
                .wdata (bus.rdata),
                .rdata (lane_rd[w][l])
            );
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= idle;
            ar_pend     <= 1'b0;
            fetch_valid <= 1'b0;
            cnt         <= '0;
            valid_q     <= '{default: '0};
            lru_q       <= '0;
        end else begin
            fetch_valid <= 1'b0;
            if (bus.arvalid && bus.arready) begin
                ar_pend <= 1'b0;
            end
            case (state)
                idle: begin
                    if (fetch_req) begin
                        state <= lookup;
                    end
                end
                lookup: begin
                    cnt <= '0;
                    if (no_cache_q) begin
                        state   <= uncached;
                        ar_pend <= 1'b1;
                    end else if (hit) begin
                        fetch_valid    <= 1'b1;
                        lru_q[pc_idx]  <= ~hit_way;   // point away from hitting way
                        state          <= idle;
                    end else begin
                        state   <= refill;
                        ar_pend <= 1'b1;
                    end
                end
                refill: begin
                    if (beat) begin
                        cnt <= cnt + 1'b1;
                    end
                    if (beat_last) begin
                        valid_q[victim][pc_idx] <= 1'b1;
                        lru_q[pc_idx]           <= ~victim;
                        fetch_valid             <= 1'b1;
                        state                   <= idle;
                    end
                end
                uncached: begin
                    if (beat) begin
                        fetch_valid <= 1'b1;
                        state       <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && fetch_req) begin
            pc_q       <= fetch_pc;
            no_cache_q <= fetch_no_cache;
        end
        if (state == lookup && hit && !no_cache_q) begin
            fetch_word0       <= lane_rd[hit_way][off0];
            fetch_word1       <= lane_rd[hit_way][off1];
            fetch_word1_valid <= !last_word;
        end
        // grab the two wanted words as the line streams in
        if (state == refill && beat) begin
            if (cnt == off0) begin
                fetch_word0 <= bus.rdata;
            end
            if (cnt == off1 && !last_word) begin
                fetch_word1 <= bus.rdata;
            end
            fetch_word1_valid <= !last_word;
        end
        if (state == uncached && beat) begin
            fetch_word0       <= bus.rdata;
            fetch_word1       <= '0;
            fetch_word1_valid <= 1'b0;
        end
    end

    // line-aligned burst, or the exact pc for one beat
    assign bus.araddr  = (state == uncached) ? pc_q
                                             : {pc_tag, pc_idx, {offset_width{1'b0}}};
    assign bus.arlen   = (state == uncached) ? '0 : burst_len_t'(words_per_line - 1);
    assign bus.arvalid = ar_pend;
    assign bus.rready  = ((state == refill) || (state == uncached)) && !ar_pend;

endmodule

`default_nettype wire

// File: uncached_reader.sv
`timescale 1ns/1ps
`default_nettype none

module uncached_reader (
    input  logic           clk,
    input  logic           rst,
    input  logic           load_req,
    input  bus_pkg::addr_t load_addr,
    output logic           load_valid,
    output bus_pkg::word_t load_data,
    rd_bus_if.requester    bus
);
    import bus_pkg::*;

    addr_t addr_q;
    logic  busy;      // load in flight
    logic  ar_pend;   // address not yet accepted
    logic  beat;

    assign beat = bus.rvalid && bus.rready;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            ar_pend    <= 1'b0;
            load_valid <= 1'b0;
        end else begin
            load_valid <= 1'b0;
            if (load_req && !busy) begin
                busy    <= 1'b1;
                ar_pend <= 1'b1;
            end
            if (bus.arvalid && bus.arready) begin
                ar_pend <= 1'b0;
            end
            if (beat) begin
                busy       <= 1'b0;
                load_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_req && !busy) begin
            addr_q <= load_addr;
        end
        if (beat) begin
            load_data <= bus.rdata;
        end
    end

    assign bus.araddr  = addr_q;
    assign bus.arlen   = '0;        // single beat
    assign bus.arvalid = ar_pend;
    assign bus.rready  = busy && !ar_pend;

endmodule

`default_nettype wire

// File: read_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module read_arbiter (
    input  logic        clk,
    input  logic        rst,
    rd_bus_if.responder req0,
    rd_bus_if.responder req1,
    rd_bus_if.requester mem
);
    logic       busy;    // burst open from acceptance through rlast
    logic       owner;   // last requester served
    logic       pick;
    logic [1:0] grant;

    // round robin, favour the one not served last
    always_comb begin
        if (req0.arvalid && req1.arvalid) begin
            pick = ~owner;
        end else begin
            pick = req1.arvalid;
        end
    end

    always_comb begin
        if (busy) begin
            grant = owner ? 2'b10 : 2'b01;
        end else if (req0.arvalid || req1.arvalid) begin
            grant = pick ? 2'b10 : 2'b01;
        end else begin
            grant = 2'b00;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            owner <= 1'b1;   // requester 0 first
        end else begin
            if (mem.arvalid && mem.arready) begin
                busy  <= 1'b1;
                owner <= grant[1];
            end
            if (mem.rvalid && mem.rready && mem.rlast) begin
                busy <= 1'b0;
            end
        end
    end

    // forward the granted side
    assign mem.araddr  = grant[1] ? req1.araddr  : req0.araddr;
    assign mem.arlen   = grant[1] ? req1.arlen   : req0.arlen;
    assign mem.arvalid = grant[1] ? req1.arvalid : req0.arvalid;
    assign mem.rready  = grant[1] ? req1.rready  : req0.rready;

    assign req0.arready = grant[0] && mem.arready;
    assign req1.arready = grant[1] && mem.arready;
    assign req0.rdata   = mem.rdata;
    assign req1.rdata   = mem.rdata;
    assign req0.rvalid  = grant[0] && mem.rvalid;
    assign req1.rvalid  = grant[1] && mem.rvalid;
    assign req0.rlast   = grant[0] && mem.rlast;
    assign req1.rlast   = grant[1] && mem.rlast;

endmodule

`default_nettype wire

// File: burst_mem.sv
`timescale 1ns/1ps
`default_nettype none

module burst_mem (
    input  logic                clk,
    input  logic                rst,
    rd_bus_if.responder         bus,
    input  logic                preload_en,
    input  bus_pkg::mem_index_t preload_addr,
    input  bus_pkg::word_t      preload_data
);
    import bus_pkg::*;

    word_t      mem [mem_words];
    logic       busy;
    mem_index_t ptr;    // word pointer, wraps at the top
    burst_len_t left;   // beats remaining after this one
    logic       beat;

    assign beat = bus.rvalid && bus.rready;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (!busy) begin
            if (bus.arvalid) begin
                busy <= 1'b1;
            end
        end else if (beat && left == '0) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && bus.arvalid) begin
            ptr  <= bus.araddr[2 +: $bits(mem_index_t)];
            left <= bus.arlen;
        end else if (beat) begin
            ptr  <= ptr + 1'b1;
            left <= left - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (preload_en) begin
            mem[preload_addr] <= preload_data;
        end
    end

    assign bus.arready = !busy;
    assign bus.rvalid  = busy;
    assign bus.rdata   = mem[ptr];
    assign bus.rlast   = busy && (left == '0);

endmodule

`default_nettype wire

// File: fetch_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_subsys_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                fetch_req,
    input  logic                fetch_no_cache,
    input  bus_pkg::addr_t      fetch_pc,
    output logic                fetch_valid,
    output bus_pkg::word_t      fetch_word0,
    output bus_pkg::word_t      fetch_word1,
    output logic                fetch_word1_valid,
    input  logic                load_req,
    input  bus_pkg::addr_t      load_addr,
    output logic                load_valid,
    output bus_pkg::word_t      load_data,
    input  logic                preload_en,
    input  bus_pkg::mem_index_t preload_addr,
    input  bus_pkg::word_t      preload_data
);
    rd_bus_if icache_bus ();
    rd_bus_if load_bus ();
    rd_bus_if mem_bus ();

    icache icache_i (
        .clk               (clk),
        .rst               (rst),
        .fetch_req         (fetch_req),
        .fetch_no_cache    (fetch_no_cache),
        .fetch_pc          (fetch_pc),
        .fetch_valid       (fetch_valid),
        .fetch_word1_valid (fetch_word1_valid),
        .fetch_word0       (fetch_word0),
        .fetch_word1       (fetch_word1),
        .bus               (icache_bus.requester)
    );

    uncached_reader load_i (
        .clk        (clk),
        .rst        (rst),
        .load_req   (load_req),
        .load_addr  (load_addr),
        .load_valid (load_valid),
        .load_data  (load_data),
        .bus        (load_bus.requester)
    );

    // cache on port 0, load unit on port 1
    read_arbiter arb_i (
        .clk  (clk),
        .rst  (rst),
        .req0 (icache_bus.responder),
        .req1 (load_bus.responder),
        .mem  (mem_bus.requester)
    );

    burst_mem mem_i (
        .clk          (clk),
        .rst          (rst),
        .bus          (mem_bus.responder),
        .preload_en   (preload_en),
        .preload_addr (preload_addr),
        .preload_data (preload_data)
    );

endmodule

`default_nettype wire

// File: fetch_subsys_checker.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_subsys_checker (
    input logic           clk,
    input logic           rst,
    input logic           fetch_req,
    input logic           fetch_valid,
    input logic           arvalid,
    input logic           arready,
    input bus_pkg::addr_t araddr,
    input logic           rvalid,
    input logic           rready,
    input logic           rlast,
    input logic [1:0]     grant
);
    logic fetch_open;   // fetch strobed, no response yet
    logic burst_open;   // address accepted, last beat not seen

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_open <= 1'b0;
            burst_open <= 1'b0;
        end else begin
            if (fetch_valid) begin
                fetch_open <= 1'b0;
            end
            if (fetch_req) begin
                fetch_open <= 1'b1;
            end
            if (arvalid && arready) begin
                burst_open <= 1'b1;
            end
            if (rvalid && rready && rlast) begin
                burst_open <= 1'b0;
            end
        end
    end

    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("mem_bus arvalid dropped or araddr changed before arready");

    // one owner at most, and it keeps the bus until the last beat
    a_one_grant: assert property (@(posedge clk) disable iff (rst)
        $onehot0(grant) && (!burst_open || ($onehot(grant) && $stable(grant))))
        else $error("grant not unique or moved while a burst was open");

    a_fetch_resp: assert property (@(posedge clk) disable iff (rst)
        fetch_valid |-> fetch_open)
        else $error("fetch_valid without an open fetch request");

    a_beat_in_burst: assert property (@(posedge clk) disable iff (rst)
        rvalid |-> burst_open)
        else $error("rvalid outside an accepted burst");

endmodule

bind fetch_subsys_top fetch_subsys_checker chk_i (
    .clk         (clk),
    .rst         (rst),
    .fetch_req   (fetch_req),
    .fetch_valid (fetch_valid),
    .arvalid     (mem_bus.arvalid),
    .arready     (mem_bus.arready),
    .araddr      (mem_bus.araddr),
    .rvalid      (mem_bus.rvalid),
    .rready      (mem_bus.rready),
    .rlast       (mem_bus.rlast),
    .grant       (arb_i.grant)
);

`default_nettype wire

// File: tb_fetch_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_subsys;
    import bus_pkg::*;

    localparam int n_steps         = 16;
    localparam int preload_words   = 4096;
    localparam int watchdog_cycles = preload_words + 5 + 60 * n_steps;

    typedef enum logic [1:0] {
        op_fetch,
        op_nocache,
        op_load,
        op_both      // fetch and load in one cycle
    } op_t;

    typedef struct packed {
        op_t   op;
        addr_t addr;
        logic  hit;
    } step_t;

    logic       clk;
    logic       rst;
    logic       fetch_req;
    logic       fetch_no_cache;
    addr_t      fetch_pc;
    logic       fetch_valid;
    word_t      fetch_word0;
    word_t      fetch_word1;
    logic       fetch_word1_valid;
    logic       load_req;
    addr_t      load_addr;
    logic       load_valid;
    word_t      load_data;
    logic       preload_en;
    mem_index_t preload_addr;
    word_t      preload_data;

    step_t       steps [n_steps];
    word_t       model [preload_words];
    logic [31:0] lfsr;
    int          cyc = 0;
    int          data_errs = 0;
    int          timing_errs = 0;
    int          strobe_errs = 0;

    fetch_subsys_top dut_i (
        .clk               (clk),
        .rst               (rst),
        .fetch_req         (fetch_req),
        .fetch_no_cache    (fetch_no_cache),
        .fetch_pc          (fetch_pc),
        .fetch_valid       (fetch_valid),
        .fetch_word0       (fetch_word0),
        .fetch_word1       (fetch_word1),
        .fetch_word1_valid (fetch_word1_valid),
        .load_req          (load_req),
        .load_addr         (load_addr),
        .load_valid        (load_valid),
        .load_data         (load_data),
        .preload_en        (preload_en),
        .preload_addr      (preload_addr),
        .preload_data      (preload_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_word(output word_t w);
        w = '0;
        for (int b = 0; b < 32; b++) begin
            lfsr = lfsr_next(lfsr);
            w    = {w[30:0], lfsr[0]};
        end
    endtask

    // table addresses keep bits 15:14 clear, so memory word = addr[13:2]
    function automatic word_t model_word(input addr_t a);
        return model[a[13:2]];
    endfunction

    function automatic step_t make_step(input op_t op, input addr_t a, input logic hit);
        step_t s;
        s.op   = op;
        s.addr = a;
        s.hit  = hit;
        return s;
    endfunction

    task automatic fill_table();
        steps[0]  = make_step(op_fetch,   32'h0000_0108, 1'b0);  // cold miss
        steps[1]  = make_step(op_fetch,   32'h0000_0100, 1'b1);
        steps[2]  = make_step(op_fetch,   32'h0000_011c, 1'b1);  // offset 7 on a hit
        steps[3]  = make_step(op_fetch,   32'h0000_03fc, 1'b0);  // offset 7 on a refill
        // A, B and C all land in set 0x20
        steps[4]  = make_step(op_fetch,   32'h0000_0400, 1'b0);  // A
        steps[5]  = make_step(op_fetch,   32'h0000_2404, 1'b0);  // B
        steps[6]  = make_step(op_fetch,   32'h0000_0414, 1'b1);  // A again
        steps[7]  = make_step(op_fetch,   32'h0002_2408, 1'b0);  // C evicts B
        steps[8]  = make_step(op_fetch,   32'h0000_0418, 1'b1);  // A kept
        steps[9]  = make_step(op_fetch,   32'h0000_2400, 1'b0);  // B gone
        steps[10] = make_step(op_nocache, 32'h0000_0604, 1'b0);
        steps[11] = make_step(op_fetch,   32'h0000_0600, 1'b0);  // nothing allocated
        steps[12] = make_step(op_fetch,   32'h0000_0604, 1'b1);
        steps[13] = make_step(op_load,    32'h0000_0a0c, 1'b0);
        steps[14] = make_step(op_both,    32'h0000_0804, 1'b0);  // load at addr + 0x1000
        steps[15] = make_step(op_both,    32'h0000_0808, 1'b1);
    endtask

    task automatic check_fetch(input int i, input step_t s, input int lat);
        word_t exp0;
        word_t exp1;
        logic  exp1v;
        exp0  = model_word(s.addr);
        exp1  = model_word(s.addr + 32'd4);
        exp1v = (s.op != op_nocache) && (s.addr[4:2] != 3'd7);
        if (fetch_word0 !== exp0) begin
            data_errs++;
            $display("[FAIL] %0t: step %0d word0 %h, expected %h", $time, i, fetch_word0, exp0);
        end
        if (fetch_word1_valid !== exp1v) begin
            data_errs++;
            $display("[FAIL] %0t: step %0d word1_valid %b, expected %b",
                     $time, i, fetch_word1_valid, exp1v);
        end
        if (exp1v && fetch_word1 !== exp1) begin
            data_errs++;
            $display("[FAIL] %0t: step %0d word1 %h, expected %h", $time, i, fetch_word1, exp1);
        end
        // a hit answers in exactly two cycles, anything through the bus takes longer
        if (s.op != op_nocache && s.hit && lat != 2) begin
            timing_errs++;
            $display("[FAIL] %0t: step %0d hit latency %0d, expected 2", $time, i, lat);
        end
        if ((s.op == op_nocache || !s.hit) && lat <= 2) begin
            timing_errs++;
            $display("[FAIL] %0t: step %0d latency %0d, expected a miss", $time, i, lat);
        end
    endtask

    task automatic check_load(input int i, input addr_t a);
        if (load_data !== model_word(a)) begin
            data_errs++;
            $display("[FAIL] %0t: step %0d load data %h, expected %h",
                     $time, i, load_data, model_word(a));
        end
    endtask

    task automatic run_step(input int i);
        step_t s;
        logic  f_pend;
        logic  l_pend;
        addr_t l_addr;
        int    start;
        s      = steps[i];
        f_pend = (s.op != op_load);
        l_pend = (s.op == op_load) || (s.op == op_both);
        l_addr = (s.op == op_both) ? s.addr + 32'h0000_1000 : s.addr;
        @(negedge clk);
        fetch_req      = f_pend;
        fetch_no_cache = (s.op == op_nocache);
        fetch_pc       = s.addr;
        load_req       = l_pend;
        load_addr      = l_addr;
        start          = cyc;
        while (f_pend || l_pend) begin
            @(negedge clk);
            fetch_req = 1'b0;
            load_req  = 1'b0;
            if (fetch_valid && !f_pend) begin
                strobe_errs++;
                $display("fetch_valid came with no fetch outstanding in step %0d", i);
            end else if (fetch_valid) begin
                f_pend = 1'b0;
                check_fetch(i, s, cyc - start);
            end
            if (load_valid && !l_pend) begin
                strobe_errs++;
                $display("load_valid came with no load outstanding in step %0d", i);
            end else if (load_valid) begin
                l_pend = 1'b0;
                check_load(i, l_addr);
            end
        end
    endtask

    initial begin
        word_t w;
        rst            = 1'b1;
        fetch_req      = 1'b0;
        fetch_no_cache = 1'b0;
        fetch_pc       = '0;
        load_req       = 1'b0;
        load_addr      = '0;
        preload_en     = 1'b0;
        preload_addr   = '0;
        preload_data   = '0;
        lfsr           = 32'd83;
        fill_table();
        repeat (5) @(negedge clk);
        rst = 1'b0;

        for (int a = 0; a < preload_words; a++) begin
            draw_word(w);
            model[a] = w;
            @(negedge clk);
            preload_en   = 1'b1;
            preload_addr = mem_index_t'(a);
            preload_data = w;
        end
        @(negedge clk);
        preload_en = 1'b0;

        for (int i = 0; i < n_steps; i++) begin
            run_step(i);
        end
        repeat (4) @(negedge clk);

        $display("errors: data %0d, timing %0d, strobe %0d", data_errs, timing_errs, strobe_errs);
        if (data_errs + timing_errs + strobe_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // preload, reset and a generous budget per step
    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: run still going after %0d cycles", watchdog_cycles);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
bus_pkg.sv
cache_pkg.sv
rd_bus_if.sv
icache_ram.sv
icache.sv
uncached_reader.sv
read_arbiter.sv
burst_mem.sv
fetch_subsys_top.sv
fetch_subsys_checker.sv
tb_fetch_subsys.sv

// File: Makefile
TOOL  = verilator
TOP   = tb_fetch_subsys
FLIST = vlog.f
FLAGS = --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP)
OBJ   = obj_dir
LOG   = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) -f $(FLIST) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)
